// File: sources.f
fp16Pkg.sv
fpRoundPkg.sv
fpRoundCfg.sv
fpRound16.sv
fpRoundTop.sv
fpRound_properties.sv
tb_fpRound.sv

// File: Makefile
# Verilator build and run of the binary16 rounder testbench
TOP := tb_fpRound

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 2>&1 | tee sim.log
	@if grep -q -e "Result: FAILED" -e "%Error" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "Result: PASSED" sim.log || { echo "no result line in sim.log"; exit 1; }

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir sim.log

// File: tb_fpRound.sv
// --------------------
// testbench for the binary16 rounding subsystem
// runs a table of rounding cases through the top level under random
// output back-pressure, then checks the sticky status and its clear
// --------------------

`timescale 1ns/1ps

module tb_fpRound;

	import fp16Pkg::*;
	import fpRoundPkg::*;

	logic      clk;
	logic      rst;
	cfgCmd_t   cfg;
	fp16In_t   inData;
	logic      inValid;
	logic      inReady;
	fp16_t     outData;
	rndFlags_t outFlags;
	logic      outValid;
	logic      outReady;
	rndFlags_t status;

	integer    seed = 51583;  // back-pressure pattern
	string     names[$];      // test table, one entry per index
	rndMode_e  modes[$];
	fp16In_t   ins[$];
	fp16_t     expOut[$];
	rndFlags_t expFlags[$];
	int        numTests = 0;
	int        passCount = 0;
	int        failCount = 0;
	int        xferCount = 0;  // output transfers seen
	bit        tableReady = 0;

	fpRoundTop i_fpRoundTop (.*);

	bind fpRound16 fpRound_properties i_fpRoundProps (
		.clk(clk), .rst(rst), .inValid(inValid), .inReady(inReady),
		.outValid(outValid), .outReady(outReady), .outData(outData)
	);

	// --------------------
	// clock, back-pressure, monitors
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		outReady = 1'b0;
		forever begin
			@(posedge clk);
			#1 outReady = (($random(seed) & 3) != 0);  // ready about 3 cycles in 4
		end
	end

	// count transfers half a cycle before the edge that takes them
	always @(negedge clk) begin
		if (!rst && outValid && outReady) begin
			xferCount++;
		end
	end

	initial begin
		wait (tableReady);
		repeat (numTests * 20 + 100) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", numTests * 20 + 100);
		$display("Result: FAILED");
		$finish;
	end

	// --------------------
	// table helpers
	function automatic fp16In_t makeIn(logic s, logic [4:0] e, logic l, logic [9:0] f,
			logic [2:0] grs);
		fp16In_t v;
		v = '{sign: s, exp: e, lead: l, frac: f, guard: grs[2], rnd: grs[1], sticky: grs[0]};
		return v;
	endfunction

	function automatic fp16_t makeOut(logic s, logic [4:0] e, logic [9:0] f);
		return '{sign: s, exp: e, frac: f};
	endfunction

	function automatic rndFlags_t makeFlags(logic ix, logic ov);
		return '{inexact: ix, overflow: ov};
	endfunction

	task automatic addTest(string n, rndMode_e m, fp16In_t d, fp16_t o, rndFlags_t f);
		names.push_back(n);
		modes.push_back(m);
		ins.push_back(d);
		expOut.push_back(o);
		expFlags.push_back(f);
	endtask

	// expected values worked out by hand from the rounding rule
	task automatic loadTable();
		addTest("rne tie L0", RM_RNE, makeIn(0, 5'd15, 1, 10'h000, 3'b100),
			makeOut(0, 5'd15, 10'h000), makeFlags(1, 0));
		addTest("rne tie L1", RM_RNE, makeIn(0, 5'd15, 1, 10'h001, 3'b100),
			makeOut(0, 5'd15, 10'h002), makeFlags(1, 0));
		addTest("rne above half", RM_RNE, makeIn(0, 5'd15, 1, 10'h000, 3'b101),
			makeOut(0, 5'd15, 10'h001), makeFlags(1, 0));
		addTest("rne below half", RM_RNE, makeIn(0, 5'd15, 1, 10'h001, 3'b011),
			makeOut(0, 5'd15, 10'h001), makeFlags(1, 0));
		addTest("rne exact", RM_RNE, makeIn(0, 5'd15, 1, 10'h001, 3'b000),
			makeOut(0, 5'd15, 10'h001), makeFlags(0, 0));
		addTest("rtz all set", RM_RTZ, makeIn(0, 5'd15, 1, 10'h001, 3'b111),
			makeOut(0, 5'd15, 10'h001), makeFlags(1, 0));
		addTest("rtz negative", RM_RTZ, makeIn(1, 5'd15, 1, 10'h000, 3'b100),
			makeOut(1, 5'd15, 10'h000), makeFlags(1, 0));
		addTest("rtz tie L0", RM_RTZ, makeIn(0, 5'd15, 1, 10'h000, 3'b100),
			makeOut(0, 5'd15, 10'h000), makeFlags(1, 0));
		addTest("rtz tie L1", RM_RTZ, makeIn(0, 5'd15, 1, 10'h001, 3'b100),
			makeOut(0, 5'd15, 10'h001), makeFlags(1, 0));
		addTest("rtz below half", RM_RTZ, makeIn(0, 5'd15, 1, 10'h001, 3'b011),
			makeOut(0, 5'd15, 10'h001), makeFlags(1, 0));
		addTest("rup positive", RM_RUP, makeIn(0, 5'd15, 1, 10'h000, 3'b001),
			makeOut(0, 5'd15, 10'h001), makeFlags(1, 0));
		addTest("rup negative", RM_RUP, makeIn(1, 5'd15, 1, 10'h000, 3'b001),
			makeOut(1, 5'd15, 10'h000), makeFlags(1, 0));
		addTest("rup tie L0", RM_RUP, makeIn(0, 5'd15, 1, 10'h000, 3'b100),
			makeOut(0, 5'd15, 10'h001), makeFlags(1, 0));
		addTest("rup tie L1", RM_RUP, makeIn(0, 5'd15, 1, 10'h001, 3'b100),
			makeOut(0, 5'd15, 10'h002), makeFlags(1, 0));
		addTest("rup below half", RM_RUP, makeIn(0, 5'd15, 1, 10'h001, 3'b011),
			makeOut(0, 5'd15, 10'h002), makeFlags(1, 0));
		addTest("rdn negative", RM_RDN, makeIn(1, 5'd15, 1, 10'h000, 3'b001),
			makeOut(1, 5'd15, 10'h001), makeFlags(1, 0));
		addTest("rdn positive", RM_RDN, makeIn(0, 5'd15, 1, 10'h000, 3'b001),
			makeOut(0, 5'd15, 10'h000), makeFlags(1, 0));
		addTest("rdn tie L0", RM_RDN, makeIn(1, 5'd15, 1, 10'h000, 3'b100),
			makeOut(1, 5'd15, 10'h001), makeFlags(1, 0));
		addTest("rdn tie L1", RM_RDN, makeIn(1, 5'd15, 1, 10'h001, 3'b100),
			makeOut(1, 5'd15, 10'h002), makeFlags(1, 0));
		addTest("rdn below half", RM_RDN, makeIn(1, 5'd15, 1, 10'h001, 3'b011),
			makeOut(1, 5'd15, 10'h002), makeFlags(1, 0));
		addTest("rmm tie L0", RM_RMM, makeIn(0, 5'd15, 1, 10'h000, 3'b100),
			makeOut(0, 5'd15, 10'h001), makeFlags(1, 0));
		addTest("rmm tie L1", RM_RMM, makeIn(0, 5'd15, 1, 10'h001, 3'b100),
			makeOut(0, 5'd15, 10'h002), makeFlags(1, 0));
		addTest("rmm below half", RM_RMM, makeIn(0, 5'd15, 1, 10'h001, 3'b011),
			makeOut(0, 5'd15, 10'h001), makeFlags(1, 0));
		addTest("frac carry", RM_RNE, makeIn(0, 5'd15, 1, 10'h3ff, 3'b110),
			makeOut(0, 5'd16, 10'h000), makeFlags(1, 0));
		addTest("subnormal up", RM_RNE, makeIn(0, 5'd0, 0, 10'h3ff, 3'b110),
			makeOut(0, 5'd1, 10'h000), makeFlags(1, 0));
		addTest("max to inf", RM_RNE, makeIn(0, 5'd30, 1, 10'h3ff, 3'b110),
			makeOut(0, 5'd31, 10'h000), makeFlags(1, 1));
		addTest("inf passthru", RM_RUP, makeIn(0, 5'd31, 1, 10'h000, 3'b111),
			makeOut(0, 5'd31, 10'h000), makeFlags(0, 0));
		addTest("nan passthru", RM_RUP, makeIn(0, 5'd31, 1, 10'h200, 3'b111),
			makeOut(0, 5'd31, 10'h200), makeFlags(0, 0));
	endtask

	// --------------------
	// bus tasks, called and returning 1 ns after a rising edge
	task automatic sendCommand(cfgOp_e op, rndMode_e m);
		cfg = '{valid: 1'b1, op: op, mode: m};
		@(posedge clk);
		#1 cfg = '0;
	endtask

	task automatic pushInput(fp16In_t d);
		inData = d;
		inValid = 1'b1;
		do @(negedge clk); while (!inReady);  // accepted at the next edge
		@(posedge clk);
		#1 inValid = 1'b0;
		inData = '0;  // idle value, unlike any pending result
	endtask

	// waits for the output transfer, result must not move while held
	task automatic collectOutput(string name, output fp16_t data, output rndFlags_t flags,
			output bit heldOk);
		fp16_t held;
		bit    seen;
		bit    done;
		seen = 0;
		done = 0;
		heldOk = 1;
		while (!done) begin
			@(negedge clk);
			if (outValid) begin
				if (!seen) begin
					held = outData;
					seen = 1;
				end
				assert (outData == held) else begin
					$display("Mismatch %s held data: expected %h, actual %h", name, held, outData);
					heldOk = 0;
				end
				done = outReady;
			end
		end
		data = outData;
		flags = outFlags;
		@(posedge clk);
		#1;
	endtask

	task automatic reportTest(string name, bit ok);
		if (ok) begin
			passCount++;
			$display("test %-16s passed", name);
		end else begin
			failCount++;
			$display("test %-16s failed", name);
		end
	endtask

	// --------------------
	// main sequence
	initial begin
		rndMode_e  curMode;
		rndFlags_t expStatus;
		fp16_t     gotData;
		rndFlags_t gotFlags;
		bit        ok;
		curMode = RM_RNE;  // mode after reset
		expStatus = '0;
		rst = 1'b1;
		cfg = '0;
		inData = '0;
		inValid = 1'b0;
		loadTable();
		numTests = names.size();
		tableReady = 1;
		repeat (5) @(posedge clk);
		#1 rst = 1'b0;

		for (int i = 0; i < numTests; i++) begin
			if (modes[i] != curMode) begin
				sendCommand(CFG_SET_MODE, modes[i]);
				@(posedge clk);
				#1 curMode = modes[i];
			end
			pushInput(ins[i]);
			collectOutput(names[i], gotData, gotFlags, ok);
			assert (gotData == expOut[i]) else begin
				$display("Mismatch %s data: expected %h, actual %h", names[i], expOut[i], gotData);
				ok = 0;
			end
			assert (gotFlags == expFlags[i]) else begin
				$display("Mismatch %s flags: expected %b, actual %b", names[i], expFlags[i],
					gotFlags);
				ok = 0;
			end
			reportTest(names[i], ok);
			expStatus = expStatus | expFlags[i];  // sticky accumulation
		end

		// status lags the last transfer by one edge
		repeat (2) @(posedge clk);
		@(negedge clk);
		ok = 1;
		assert (status == expStatus) else begin
			$display("Mismatch status accumulate: expected %b, actual %b", expStatus, status);
			ok = 0;
		end
		reportTest("status accumulate", ok);

		@(posedge clk);
		#1 sendCommand(CFG_CLR_FLAGS, RM_RNE);
		@(negedge clk);
		ok = 1;
		assert (status == '0) else begin
			$display("Mismatch status clear: expected 00, actual %b", status);
			ok = 0;
		end
		reportTest("status clear", ok);

		ok = 1;  // one delivered result per table entry
		assert (xferCount == numTests) else begin
			$display("Mismatch transfer count: expected %0d, actual %0d", numTests, xferCount);
			ok = 0;
		end
		reportTest("transfer count", ok);

		ok = 1;  // bound handshake and reset assertions
		assert (i_fpRoundTop.i_fpRound16.i_fpRoundProps.violations == 0) else begin
			$display("handshake assertions failed %0d times during the run",
				i_fpRoundTop.i_fpRound16.i_fpRoundProps.violations);
			ok = 0;
		end
		reportTest("handshake rules", ok);

		$display("tests: %0d passed, %0d failed", passCount, failCount);
		if (failCount == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: fpRound_properties.sv
// --------------------
// handshake and reset properties of the rounding stage
// bound onto every fpRound16 instance from the testbench
// --------------------

`timescale 1ns/1ps

module fpRound_properties (
	input logic           clk,
	input logic           rst,
	input logic           inValid,
	input logic           inReady,
	input logic           outValid,
	input logic           outReady,
	input fp16Pkg::fp16_t outData
);

	int violations = 0;  // failed assertions so far, read by the testbench

	// --------------------
	// reset leaves the stage empty
	resetEmpty: assert property (@(posedge clk) rst |=> !outValid)
		else begin
			$error("outValid still high in the cycle after reset");
			violations++;
		end

	// a held result keeps its valid and its data
	holdStable: assert property (@(posedge clk) disable iff (rst)
		(outValid && !outReady) |=> (outValid && $stable(outData)))
		else begin
			$error("output changed while stalled by back-pressure");
			violations++;
		end

	// ready whenever the output is free or draining
	readyRule: assert property (@(posedge clk) disable iff (rst)
		inReady == (!outValid || outReady))
		else begin
			$error("inReady does not follow the handshake rule");
			violations++;
		end

	// --------------------
	// one cycle from input transfer to output valid
	validAfterXfer: assert property (@(posedge clk) disable iff (rst)
		(inValid && inReady) |=> outValid)
		else begin
			$error("no valid output one cycle after an input transfer");
			violations++;
		end

	// stage advancing with nothing coming in goes empty
	emptyAfterIdle: assert property (@(posedge clk) disable iff (rst)
		(inReady && !inValid) |=> !outValid)
		else begin
			$error("outValid high without a preceding input transfer");
			violations++;
		end

endmodule

// File: fpRoundTop.sv
// --------------------
// binary16 rounding subsystem top level
// config block beside a one-stage rounder, the config block supplies
// the mode and collects the rounder's flags into sticky status
// --------------------

`timescale 1ns/1ps

module fpRoundTop (
	input  logic                  clk,
	input  logic                  rst,
	input  fpRoundPkg::cfgCmd_t   cfg,       // mode / clear commands
	input  fp16Pkg::fp16In_t      inData,
	input  logic                  inValid,
	output logic                  inReady,
	output fp16Pkg::fp16_t        outData,
	output fpRoundPkg::rndFlags_t outFlags,  // flags of the current result
	output logic                  outValid,
	input  logic                  outReady,
	output fpRoundPkg::rndFlags_t status     // sticky flags
);

	import fpRoundPkg::*;

	rndMode_e  mode;       // active rounding mode
	rndFlags_t flagPulse;  // per-transfer flags into the status

	// --------------------
	// configuration and status
	fpRoundCfg i_fpRoundCfg (
		.clk       (clk),
		.rst       (rst),
		.cfg       (cfg),
		.flagPulse (flagPulse),
		.mode      (mode),
		.status    (status)
	);

	// --------------------
	// rounding stage
	fpRound16 i_fpRound16 (
		.clk       (clk),
		.rst       (rst),
		.mode      (mode),
		.inData    (inData),
		.inValid   (inValid),
		.inReady   (inReady),
		.outData   (outData),
		.outFlags  (outFlags),
		.outValid  (outValid),
		.outReady  (outReady),
		.flagPulse (flagPulse)
	);

endmodule

// File: fpRound16.sv
// --------------------
// binary16 rounder, one pipeline stage
// takes an intermediate value with guard/round/sticky bits and returns
// the rounded value plus inexact and overflow flags one cycle later
// the stage enable comes from a valid/ready handshake on both sides
// --------------------

`timescale 1ns/1ps

module fpRound16 (
	input  logic                  clk,
	input  logic                  rst,
	input  fpRoundPkg::rndMode_e  mode,      // mode held at the accepting edge
	input  fp16Pkg::fp16In_t      inData,
	input  logic                  inValid,
	output logic                  inReady,
	output fp16Pkg::fp16_t        outData,
	output fpRoundPkg::rndFlags_t outFlags,
	output logic                  outValid,
	input  logic                  outReady,
	output fpRoundPkg::rndFlags_t flagPulse  // outFlags, only during the output transfer
);

	import fp16Pkg::*;
	import fpRoundPkg::*;

	localparam int MAG_W = EXP_W + FRAC_W;  // exponent and fraction side by side

	logic             isSpecial;  // inf or NaN input
	logic             anyGrs;     // any bit below the lsb set
	logic             rnd;        // round increment
	logic [MAG_W-1:0] magIn;
	logic [MAG_W-1:0] magRnd;
	logic             ovf;
	fp16_t            resNext;
	rndFlags_t        flagsNext;
	logic             xferIn;     // input transfer this cycle

	// --------------------
	// round increment
	assign isSpecial = (inData.exp == EXP_MAX);
	assign anyGrs    = inData.guard | inData.rnd | inData.sticky;

	always_comb begin
		case (mode)
			RM_RNE:  rnd = inData.guard & (inData.rnd | inData.sticky | inData.frac[0]);
			RM_RTZ:  rnd = 1'b0;                    // plain truncation
			RM_RUP:  rnd = anyGrs & ~inData.sign;   // away from zero when positive
			RM_RDN:  rnd = anyGrs & inData.sign;    // away from zero when negative
			RM_RMM:  rnd = inData.guard;            // ties go up in magnitude
			default: rnd = 1'b0;                    // unused codes truncate
		endcase
		if (isSpecial) begin
			rnd = 1'b0;  // inf and NaN are never rounded
		end
	end

	// --------------------
	// add the increment onto the fraction lsb
	// a carry out of the fraction bumps the exponent, which also turns
	// a subnormal with an all-ones fraction into the smallest normal
	assign magIn  = {inData.exp, inData.frac};
	assign magRnd = magIn + {{(MAG_W-1){1'b0}}, rnd};

	// exponent can only reach all-ones here through the carry
	assign ovf = (magRnd[MAG_W-1 -: EXP_W] == EXP_MAX) && !isSpecial;

	always_comb begin
		resNext.sign = inData.sign;             // sign never changes
		resNext.exp  = magRnd[MAG_W-1 -: EXP_W];
		resNext.frac = ovf ? '0 : magRnd[FRAC_W-1:0];  // overflow gives infinity

		flagsNext.inexact  = anyGrs && !isSpecial;
		flagsNext.overflow = ovf;
	end

	// --------------------
	// handshake and stage register
	// the stage moves whenever the output is empty or being drained
	assign inReady = !outValid || outReady;
	assign xferIn  = inValid && inReady;

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (inReady) begin
			outValid <= inValid;  // refill or go empty
		end
	end

	// payload loads only on an accepted input, held under back-pressure
	always_ff @(posedge clk) begin
		if (xferIn) begin
			outData  <= resNext;
			outFlags <= flagsNext;
		end
	end

	// flags for the sticky status, one pulse per delivered result
	assign flagPulse = (outValid && outReady) ? outFlags : '0;

endmodule

// File: fpRoundCfg.sv
// --------------------
// rounding configuration block
// holds the active rounding mode and the sticky status flags,
// written through the command port, flags come in as one-cycle pulses
// from the rounder's output transfer
// --------------------

`timescale 1ns/1ps

module fpRoundCfg (
	input  logic                  clk,
	input  logic                  rst,
	input  fpRoundPkg::cfgCmd_t   cfg,        // command, no back-pressure
	input  fpRoundPkg::rndFlags_t flagPulse,  // flags of the result leaving this cycle
	output fpRoundPkg::rndMode_e  mode,       // mode seen by the rounder
	output fpRoundPkg::rndFlags_t status      // sticky flags
);

	import fpRoundPkg::*;

	logic setMode;   // CFG_SET_MODE this cycle
	logic clrFlags;  // CFG_CLR_FLAGS this cycle

	// --------------------
	// command decode
	assign setMode  = cfg.valid && (cfg.op == CFG_SET_MODE);
	assign clrFlags = cfg.valid && (cfg.op == CFG_CLR_FLAGS);

	// --------------------
	// mode register
	// new mode applies to inputs accepted from the next cycle on
	always_ff @(posedge clk) begin
		if (rst) begin
			mode <= RM_RESET;
		end else if (setMode) begin
			mode <= cfg.mode;
		end
	end

	// --------------------
	// sticky status
	// a clear keeps only the bits pulsed in the same cycle,
	// so a simultaneous flag pulse survives the clear
	always_ff @(posedge clk) begin
		if (rst) begin
			status <= '0;
		end else if (clrFlags) begin
			status <= flagPulse;           // set beats clear
		end else begin
			status <= status | flagPulse;  // accumulate
		end
	end

endmodule

// File: fpRoundPkg.sv
// --------------------
// rounding control definitions
// rounding modes, configuration commands and the status flag layout
// shared by the config block, the rounder, the top level and the testbench
// --------------------

package fpRoundPkg;

	// rounding modes, codes 5..7 are unused and round toward zero
	typedef enum logic [2:0] {
		RM_RNE = 3'd0,  // nearest, ties to even
		RM_RTZ = 3'd1,  // toward zero
		RM_RUP = 3'd2,  // toward +inf
		RM_RDN = 3'd3,  // toward -inf
		RM_RMM = 3'd4   // nearest, ties away from zero
	} rndMode_e;

	// mode loaded by reset
	localparam rndMode_e RM_RESET = RM_RNE;

	// configuration opcodes
	typedef enum logic [1:0] {
		CFG_NOP       = 2'd0,
		CFG_SET_MODE  = 2'd1,  // load mode field into the mode register
		CFG_CLR_FLAGS = 2'd2   // clear sticky status
	} cfgOp_e;

	// one-cycle command, acts only when valid is set
	typedef struct packed {
		logic     valid;
		cfgOp_e   op;
		rndMode_e mode;
	} cfgCmd_t;

	// per-result flags, also used for the sticky status
	typedef struct packed {
		logic inexact;
		logic overflow;
	} rndFlags_t;

endpackage

// File: fp16Pkg.sv
// --------------------
// binary16 format definitions shared by the rounder and its testbench
// intermediate values come in with extra guard, round and sticky bits,
// rounded values leave in plain IEEE 754 half-precision layout
// --------------------

package fp16Pkg;

	// --------------------
	// field widths
	localparam int EXP_W  = 5;   // biased exponent
	localparam int FRAC_W = 10;  // stored fraction, hidden bit not included

	// all-ones exponent marks infinity (frac 0) or NaN (frac != 0)
	localparam logic [EXP_W-1:0] EXP_MAX = '1;

	// --------------------
	// intermediate value from the upstream arithmetic unit
	// lead is the explicit leading bit, lead 0 with exp 0 is a subnormal
	typedef struct packed {
		logic              sign;
		logic [EXP_W-1:0]  exp;
		logic              lead;
		logic [FRAC_W-1:0] frac;
		logic              guard;   // first bit below the fraction lsb
		logic              rnd;     // second bit below the lsb
		logic              sticky;  // or of everything further down
	} fp16In_t;

	// rounded binary16 result
	typedef struct packed {
		logic              sign;
		logic [EXP_W-1:0]  exp;
		logic [FRAC_W-1:0] frac;
	} fp16_t;

endpackage
